// ==== tb.f ====
src/mcpu_pkg.sv
src/map_rom.sv
src/micro_rom.sv
src/micro_sequencer.sv
src/datapath.sv
src/main_memory.sv
src/mcpu_top.sv
bench/mcpu_properties.sv
bench/tb_mcpu.sv

// ==== run.sh ====
#!/bin/sh
# builds the CPU testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mcpu -f tb.f

sim_output=$(./obj_dir/Vtb_mcpu +verilator+error+limit+100 2>&1) || {
   echo "$sim_output"
   exit 1
}
echo "$sim_output"

if echo "$sim_output" | grep -q "^TEST RESULT: PASS$"; then
   exit 0
fi
exit 1

// ==== map_rom.dat ====
// sparse map, each line is @opcode then the microcode start address in hex
// opcodes not listed keep the illegal marker ff
@01 02   // LDI, instruction byte 04
@02 03   // LDA, 08
@03 04   // STA, 0c
@04 05   // ADD, 10
@05 06   // SUB, 14
@06 07   // AND, 18
@07 08   // JMP, 1c
@08 09   // JZ, 20
@09 0a   // OUT, 24
@0a 0b   // HLT, 28

// ==== micro_rom.dat ====
// microcode, one 22-bit word per entry from address 0 up
// bits 21:20 next_sel, 19:12 next_addr, 11:9 alu_op, 8:0 acc_ld down to out_ld
0000a0   // 00 fetch opcode byte into ir, pc + 1
200060   // 01 fetch operand byte, pc + 1, dispatch
100300   // 02 LDI
100102   // 03 LDA
100006   // 04 STA
100502   // 05 ADD
100702   // 06 SUB
100902   // 07 AND
100010   // 08 JMP
100008   // 09 JZ
100001   // 0a OUT
300000   // 0b HLT
// 0c to 3f are unused
000000 000000 000000 000000 000000 000000 000000 000000
000000 000000 000000 000000 000000 000000 000000 000000
000000 000000 000000 000000 000000 000000 000000 000000
000000 000000 000000 000000 000000 000000 000000 000000
000000 000000 000000 000000 000000 000000 000000 000000
000000 000000 000000 000000 000000 000000 000000 000000
000000 000000 000000 000000

// ==== program.dat ====
// memory image, @ sets the byte address and each column after it is one hex byte
// every instruction is an opcode byte followed by an operand byte
@00
08 f0   // 00 LDA F0, the flag
20 06   // 02 JZ 06 while the flag is clear
1c 40   // 04 JMP 40 once the flag is set
04 01   // 06 LDI 01
0c f0   // 08 STA F0
04 05   // 0a LDI 05
10 f1   // 0c ADD F1
24 00   // 0e OUT
14 f2   // 10 SUB F2
24 00   // 12 OUT
18 f3   // 14 AND F3
24 00   // 16 OUT
04 03   // 18 LDI 03
24 00   // 1a OUT, loop head
14 f4   // 1c SUB F4
20 22   // 1e JZ 22
1c 1a   // 20 JMP 1a
28 00   // 22 HLT
@40
fc 00   // 40 undefined opcode
@f0
00 03 0a 0f 01   // f0 flag, f1 to f4 constants

// ==== bench/tb_mcpu.sv ====
// testbench for the microprogrammed CPU, runs the stored program twice and checks its outputs
`timescale 1ns/1ps
`default_nettype none

module tb_mcpu;

   import mcpu_pkg::*;

   // ********************************************************************
   // run lengths
   // ********************************************************************

   localparam int CLK_HALF     = 10;
   localparam int RESET_CYCLES = 2;
   localparam int INSTR_CYCLES = 3;
   localparam int HOLD_CYCLES  = 8;
   // run one executes 24 instructions, run two 3 and the faulting fetch
   localparam int RUN_CYCLES   = (24 + 4) * INSTR_CYCLES;
   // both runs, their resets and hold windows with room to spare
   localparam int MAX_CYCLES   = 3 * (RUN_CYCLES + HOLD_CYCLES + RESET_CYCLES);

   logic  clk;
   logic  rst;
   data_t out_data;
   logic  out_valid;
   logic  halted;
   logic  fault;

   int    cycle_count = 0;
   int    error_count = 0;
   int    tests_passed = 0;
   int    tests_failed = 0;
   int    test_start_errors = 0;
   data_t seen_data [$];
   int    seen_cycle [$];
   data_t expected_data [$];

   mcpu_top u_mcpu_top (
      .clk       (clk),
      .rst       (rst),
      .out_data  (out_data),
      .out_valid (out_valid),
      .halted    (halted),
      .fault     (fault)
   );

   bind mcpu_top mcpu_properties u_mcpu_properties (
      .clk       (clk),
      .rst       (rst),
      .out_data  (out_data),
      .out_valid (out_valid),
      .halted    (halted),
      .fault     (fault)
   );

   always #CLK_HALF clk = ~clk;

   // outputs are sampled mid-cycle, well away from the register updates
   always @(negedge clk)
   begin
      if (out_valid)
      begin
         seen_data.push_back(out_data);
         seen_cycle.push_back(cycle_count);
      end
      cycle_count = cycle_count + 1;
   end

   initial
   begin
      wait (cycle_count >= MAX_CYCLES);
      $display("run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // ********************************************************************
   // helpers
   // ********************************************************************

   task automatic check_value(input string name, input int expected, input int actual);
      assert (expected == actual)
      else
      begin
         $display("Fail %s expected %0h got %0h", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic begin_test();
      test_start_errors = error_count;
   endtask

   task automatic end_test(input string name);
      if (error_count == test_start_errors)
      begin
         tests_passed++;
         $display("test %s passed", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, error_count - test_start_errors);
      end
   endtask

   // rst goes high for two full cycles, driven just after the clock edge
   task automatic apply_reset();
      @(posedge clk);
      #1 rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst = 1'b0;
   endtask

   task automatic wait_stopped();
      while (!(halted || fault))
      begin
         @(negedge clk);
      end
   endtask

   // once stopped the levels must not move and no output may appear
   task automatic check_hold(input logic exp_halted, input logic exp_fault);
      int pulses;
      pulses = seen_data.size();
      repeat (HOLD_CYCLES)
      begin
         @(negedge clk);
         check_value("halted", int'(exp_halted), int'(halted));
         check_value("fault", int'(exp_fault), int'(fault));
         check_value("out_valid", 0, int'(out_valid));
      end
      check_value("out_valid pulse count", pulses, seen_data.size());
   endtask

   // the values the program prints, worked out from its data bytes
   task automatic build_expected();
      data_t acc;
      expected_data.delete();
      // LDI 05 then ADD of 03 from F1
      acc = 8'h05 + 8'h03;
      expected_data.push_back(acc);
      // SUB of 0a from F2 wraps below zero
      acc = acc - 8'h0a;
      expected_data.push_back(acc);
      acc = acc & 8'h0f;
      expected_data.push_back(acc);
      // countdown loop prints before each SUB of 01 and leaves at zero
      acc = 8'h03;
      while (acc != 8'h00)
      begin
         expected_data.push_back(acc);
         acc = acc - 8'h01;
      end
   endtask

   // ********************************************************************
   // test sequence
   // ********************************************************************

   initial
   begin
      int idx;
      int prop_failures;
      clk = 1'b0;
      rst = 1'b1;
      build_expected();
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst = 1'b0;

      begin_test();
      @(posedge clk);
      @(negedge clk);
      check_value("out_valid", 0, int'(out_valid));
      check_value("halted", 0, int'(halted));
      check_value("fault", 0, int'(fault));
      end_test("reset");

      // first run takes the flag path and prints six values
      begin_test();
      wait_stopped();
      check_value("out_valid pulse count", expected_data.size(), seen_data.size());
      for (idx = 0; idx < expected_data.size() && idx < seen_data.size(); idx++)
      begin
         check_value("out_data", int'(expected_data[idx]), int'(seen_data[idx]));
      end
      end_test("output values");

      // OUT, ALU op, OUT is two instructions between pulses
      begin_test();
      assert (seen_cycle.size() >= 3)
      else
      begin
         $display("fewer than three output pulses, so their spacing cannot be measured");
         error_count++;
      end
      if (seen_cycle.size() >= 3)
      begin
         check_value("pulse spacing 1 to 2", 2 * INSTR_CYCLES, seen_cycle[1] - seen_cycle[0]);
         check_value("pulse spacing 2 to 3", 2 * INSTR_CYCLES, seen_cycle[2] - seen_cycle[1]);
      end
      end_test("instruction timing");

      begin_test();
      check_value("halted", 1, int'(halted));
      check_value("fault", 0, int'(fault));
      check_hold(1'b1, 1'b0);
      end_test("halt");

      // memory kept the flag set by run one, so run two lands on byte fc
      begin_test();
      apply_reset();
      seen_data.delete();
      seen_cycle.delete();
      wait_stopped();
      check_value("fault", 1, int'(fault));
      check_value("halted", 0, int'(halted));
      check_value("out_valid pulse count", 0, seen_data.size());
      check_hold(1'b0, 1'b1);
      end_test("restart after reset");

      prop_failures = u_mcpu_top.u_mcpu_properties.fail_count;
      if (prop_failures != 0)
      begin
         $display("bound output assertions failed %0d times", prop_failures);
      end
      $display("tests passed %0d failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && prop_failures == 0)
      begin
         $display("TEST RESULT: PASS");
      end
      else
      begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/mcpu_properties.sv ====
// bound checks on the CPU outputs for pulse width, sticky halt and fault, and exclusivity
`timescale 1ns/1ps
`default_nettype none

module mcpu_properties (
   input logic            clk,
   input logic            rst,
   input mcpu_pkg::data_t out_data,
   input logic            out_valid,
   input logic            halted,
   input logic            fault
);

   import mcpu_pkg::*;

   // read by the testbench at the end of the run
   int fail_count = 0;

   // ********************************************************************
   // output strobe
   // ********************************************************************

   // every OUT gives exactly one cycle of out_valid
   assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid)
   else
   begin
      fail_count++;
      $error("out_valid stayed high for more than one cycle");
   end

   // the output register only moves together with its pulse
   assert property (@(posedge clk) disable iff (rst)
                    (out_data != $past(out_data)) |-> out_valid)
   else
   begin
      fail_count++;
      $error("out_data changed without an out_valid pulse");
   end

   // ********************************************************************
   // stopped states
   // ********************************************************************

   // both levels are held until the next reset
   assert property (@(posedge clk) disable iff (rst) halted |=> halted)
   else
   begin
      fail_count++;
      $error("halted dropped without a reset");
   end

   assert property (@(posedge clk) disable iff (rst) fault |=> fault)
   else
   begin
      fail_count++;
      $error("fault dropped without a reset");
   end

   // a stopped CPU issues no strobes, so no output either
   assert property (@(posedge clk) disable iff (rst) (halted || fault) |-> !out_valid)
   else
   begin
      fail_count++;
      $error("out_valid pulsed while the CPU was stopped");
   end

   assert property (@(posedge clk) disable iff (rst) !(halted && fault))
   else
   begin
      fail_count++;
      $error("halted and fault were high together");
   end

endmodule

`default_nettype wire

// ==== src/mcpu_top.sv ====
// top level of the microprogrammed CPU joining ROMs, sequencer, datapath and memory
`timescale 1ns/1ps
`default_nettype none

module mcpu_top (
   input  logic            clk,
   input  logic            rst,
   output mcpu_pkg::data_t out_data,
   output logic            out_valid,
   output logic            halted,
   output logic            fault
);

   import mcpu_pkg::*;

   // ROM side
   opcode_t     opcode;
   upc_t        start;
   logic        illegal;
   upc_t        upc;
   micro_word_t word;
   logic        addr_error;
   // sequencer to datapath
   ctrl_t       ctrl;
   // memory bus
   data_t       mem_addr;
   data_t       mem_wdata;
   data_t       mem_rdata;
   logic        mem_we;

   map_rom u_map_rom (
      .opcode  (opcode),
      .start   (start),
      .illegal (illegal)
   );

   micro_rom u_micro_rom (
      .upc        (upc),
      .word       (word),
      .addr_error (addr_error)
   );

   micro_sequencer u_micro_sequencer (
      .clk        (clk),
      .rst        (rst),
      .word       (word),
      .start      (start),
      .illegal    (illegal),
      .addr_error (addr_error),
      .ctrl       (ctrl),
      .upc        (upc),
      .halted     (halted),
      .fault      (fault)
   );

   datapath u_datapath (
      .clk       (clk),
      .rst       (rst),
      .ctrl      (ctrl),
      .mem_rdata (mem_rdata),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .opcode    (opcode),
      .out_data  (out_data),
      .out_valid (out_valid)
   );

   main_memory u_main_memory (
      .clk   (clk),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .we    (mem_we),
      .rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// ==== src/main_memory.sv ====
// unified 256-byte program and data memory with asynchronous read and synchronous write
`timescale 1ns/1ps
`default_nettype none

module main_memory (
   input  logic            clk,
   input  mcpu_pkg::data_t addr,
   input  mcpu_pkg::data_t wdata,
   input  logic            we,
   output mcpu_pkg::data_t rdata
);

   import mcpu_pkg::*;

   // ********************************************************************
   // storage
   // ********************************************************************

   // program and data share the one array, the contents survive rst
   data_t mem [256];

   initial
   begin
      $readmemh("program.dat", mem);
   end

   // ********************************************************************
   // access
   // ********************************************************************

   // read is combinational so a fetch completes in the same cycle
   assign rdata = mem[addr];

   // the written byte is visible to reads from the next cycle on
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[addr] <= wdata;
      end
   end

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
// datapath with pc, instruction and operand registers, accumulator, ALU and output register
`timescale 1ns/1ps
`default_nettype none

module datapath (
   input  logic              clk,
   input  logic              rst,
   input  mcpu_pkg::ctrl_t   ctrl,
   input  mcpu_pkg::data_t   mem_rdata,
   output mcpu_pkg::data_t   mem_addr,
   output mcpu_pkg::data_t   mem_wdata,
   output logic              mem_we,
   output mcpu_pkg::opcode_t opcode,
   output mcpu_pkg::data_t   out_data,
   output logic              out_valid
);

   import mcpu_pkg::*;

   data_t pc;
   data_t ir;
   data_t operand;
   data_t acc;
   data_t alu_result;
   logic  acc_zero;

   // ********************************************************************
   // memory port
   // ********************************************************************

   // fetch reads at the pc, data accesses use the operand as address
   assign mem_addr  = ctrl.addr_sel ? operand : pc;
   // STA is the only writer and always stores the accumulator
   assign mem_wdata = acc;
   assign mem_we    = ctrl.mem_wr;

   // the low two bits of an instruction byte are not decoded
   assign opcode = ir[7:2];

   // ********************************************************************
   // ALU
   // ********************************************************************

   always_comb
   begin
      case (ctrl.alu_op)
         alu_pass_mem:     alu_result = mem_rdata;
         alu_pass_operand: alu_result = operand;
         alu_add:          alu_result = acc + mem_rdata;
         alu_sub:          alu_result = acc - mem_rdata;
         alu_and:          alu_result = acc & mem_rdata;
         default:          alu_result = mem_rdata;
      endcase
   end

   // zero test on the accumulator as it stands, used by JZ
   assign acc_zero = (acc == '0);

   // ********************************************************************
   // registers
   // ********************************************************************

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc        <= '0;
         ir        <= '0;
         acc       <= '0;
         out_data  <= '0;
         out_valid <= 1'b0;
      end
      else
      begin
         // a taken jump wins over the fetch increment
         if (ctrl.pc_ld || (ctrl.pc_ld_zero && acc_zero))
         begin
            pc <= operand;
         end
         else if (ctrl.pc_inc)
         begin
            pc <= pc + data_t'(1);
         end
         if (ctrl.ir_ld)
         begin
            ir <= mem_rdata;
         end
         if (ctrl.acc_ld)
         begin
            acc <= alu_result;
         end
         if (ctrl.out_ld)
         begin
            out_data <= acc;
         end
         // one-cycle pulse following the OUT execute word
         out_valid <= ctrl.out_ld;
      end
   end

   // operand byte is plain payload, loaded in the second fetch word
   always_ff @(posedge clk)
   begin
      if (ctrl.opnd_ld)
      begin
         operand <= mem_rdata;
      end
   end

endmodule

`default_nettype wire

// ==== src/micro_sequencer.sv ====
// microsequencer with the microprogram counter, next-address choice and run/halt/fault FSM
`timescale 1ns/1ps
`default_nettype none

module micro_sequencer (
   input  logic                  clk,
   input  logic                  rst,
   input  mcpu_pkg::micro_word_t word,
   input  mcpu_pkg::upc_t        start,
   input  logic                  illegal,
   input  logic                  addr_error,
   output mcpu_pkg::ctrl_t       ctrl,
   output mcpu_pkg::upc_t        upc,
   output logic                  halted,
   output logic                  fault
);

   import mcpu_pkg::*;

   seq_state_t state;
   logic       fault_event;
   logic       ctrl_en;

   // a bad microcode address is always fatal, an undefined opcode only
   // matters on the word that dispatches on it
   assign fault_event = addr_error || ((word.next_sel == seq_dispatch) && illegal);

   // strobes reach the datapath only on a good word while running
   assign ctrl_en = (state == st_run) && !fault_event;

   // ********************************************************************
   // control strobes to the datapath
   // ********************************************************************

   always_comb
   begin
      ctrl = '0;
      if (ctrl_en)
      begin
         ctrl.alu_op     = word.alu_op;
         ctrl.acc_ld     = word.acc_ld;
         ctrl.ir_ld      = word.ir_ld;
         ctrl.opnd_ld    = word.opnd_ld;
         ctrl.pc_inc     = word.pc_inc;
         ctrl.pc_ld      = word.pc_ld;
         ctrl.pc_ld_zero = word.pc_ld_zero;
         ctrl.mem_wr     = word.mem_wr;
         ctrl.addr_sel   = word.addr_sel;
         ctrl.out_ld     = word.out_ld;
      end
   end

   // ********************************************************************
   // upc and state register
   // ********************************************************************

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         // fetch begins at word 0 on the first cycle after reset
         upc   <= '0;
         state <= st_run;
      end
      else if (state == st_run)
      begin
         if (fault_event)
         begin
            // upc stays on the offending word
            state <= st_fault;
         end
         else
         begin
            case (word.next_sel)
               seq_next:     upc <= upc + upc_t'(1);
               seq_jump:     upc <= word.next_addr;
               seq_dispatch: upc <= start;
               default:      state <= st_halted;
            endcase
         end
      end
   end

   // both levels come straight from the state register
   assign halted = (state == st_halted);
   assign fault  = (state == st_fault);

endmodule

`default_nettype wire

// ==== src/micro_rom.sv ====
// microprogram ROM holding the 22-bit control words, flags reads past the loaded depth
`timescale 1ns/1ps
`default_nettype none

module micro_rom (
   input  mcpu_pkg::upc_t      upc,
   output mcpu_pkg::micro_word_t word,
   output logic                addr_error
);

   import mcpu_pkg::*;

   // ********************************************************************
   // storage
   // ********************************************************************

   // full 256-word space of the 8-bit upc, only the low part is filled
   logic [$bits(micro_word_t)-1:0] rom_mem [256];

   initial
   begin
      // words above the loaded depth are left as they are since
      // addr_error keeps them from ever reaching the datapath
      $readmemh("micro_rom.dat", rom_mem, 0, MICRO_DEPTH - 1);
   end

   // ********************************************************************
   // read port
   // ********************************************************************

   // asynchronous read, the sequencer registers only the address
   assign word = micro_word_t'(rom_mem[upc]);

   // an address at or past the loaded depth is a microcode error
   assign addr_error = (upc >= upc_t'(MICRO_DEPTH));

endmodule

`default_nettype wire

// ==== src/map_rom.sv ====
// mapping ROM that turns an opcode into the start address of its microprogram
`timescale 1ns/1ps
`default_nettype none

module map_rom (
   input  mcpu_pkg::opcode_t opcode,
   output mcpu_pkg::upc_t    start,
   output logic              illegal
);

   import mcpu_pkg::*;

   // one entry per possible opcode
   upc_t map_mem [64];

   // every entry starts out illegal so the data file only has to list
   // the opcodes that exist, using @address lines
   initial
   begin
      for (int i = 0; i < 64; i++)
      begin
         map_mem[i] = MAP_ILLEGAL;
      end
      $readmemh("map_rom.dat", map_mem);
   end

   // plain combinational lookup
   assign start = map_mem[opcode];

   // the sequencer only acts on this while dispatching
   assign illegal = (start == MAP_ILLEGAL);

endmodule

`default_nettype wire

// ==== src/mcpu_pkg.sv ====
// shared types, control-word layout and sequencing codes for the microprogrammed accumulator CPU
`default_nettype none

package mcpu_pkg;

   // ********************************************************************
   // widths with a meaning of their own
   // ********************************************************************

   // one byte of data, a memory address or an instruction byte
   typedef logic [7:0] data_t;

   // upper six bits of an instruction byte, used to index the mapping ROM
   typedef logic [5:0] opcode_t;

   // address into the microprogram ROM
   typedef logic [7:0] upc_t;

   // number of microcode words actually loaded, anything at or above is bad
   localparam int unsigned MICRO_DEPTH = 64;

   // map entry value that marks an opcode with no microprogram
   localparam upc_t MAP_ILLEGAL = 8'hff;

   // ********************************************************************
   // control-word field codes
   // ********************************************************************

   // ALU function, the second operand is mem_rdata except for pass_operand
   typedef enum logic [2:0] {
      alu_pass_mem     = 3'd0,
      alu_pass_operand = 3'd1,
      alu_add          = 3'd2,
      alu_sub          = 3'd3,
      alu_and          = 3'd4
   } alu_op_t;

   // how the sequencer picks the next microprogram address
   typedef enum logic [1:0] {
      seq_next     = 2'd0,
      seq_jump     = 2'd1,
      seq_dispatch = 2'd2,
      seq_halt     = 2'd3
   } next_sel_t;

   // one 22-bit microcode word, msb first as stored in micro_rom.dat
   typedef struct packed {
      next_sel_t next_sel;
      upc_t      next_addr;
      alu_op_t   alu_op;
      logic      acc_ld;
      logic      ir_ld;
      logic      opnd_ld;
      logic      pc_inc;
      logic      pc_ld;
      logic      pc_ld_zero;
      logic      mem_wr;
      // 0 addresses memory with the pc, 1 with the operand register
      logic      addr_sel;
      logic      out_ld;
   } micro_word_t;

   // the datapath strobes of a control word, without the sequencing fields
   typedef struct packed {
      alu_op_t alu_op;
      logic    acc_ld;
      logic    ir_ld;
      logic    opnd_ld;
      logic    pc_inc;
      logic    pc_ld;
      logic    pc_ld_zero;
      logic    mem_wr;
      logic    addr_sel;
      logic    out_ld;
   } ctrl_t;

   // sequencer FSM, halted and fault are both sticky until reset
   typedef enum logic [1:0] {
      st_run    = 2'd0,
      st_halted = 2'd1,
      st_fault  = 2'd2
   } seq_state_t;

endpackage

`default_nettype wire
